//--- common/periph_pkg.sv
// Shared types and constants for the peripheral subsystem.
// Address map: bit 23 selects flash (byte address in 19:0), otherwise
// bits 22:20 select status (1), dsp (2) or pad (3). Anything else is unmapped.

package periph_pkg;

    typedef logic [23:0] cpu_addr_t;
    typedef logic [31:0] cpu_word_t;
    typedef logic [3:0] cpu_strb_t;
    typedef logic [19:0] flash_addr_t;

    typedef enum logic [2:0] {
        region_none,
        region_status,
        region_dsp,
        region_pad,
        region_flash
    } region_t;

    // address map fields
    localparam int unsigned flash_sel_bit = 23;
    localparam int unsigned region_sel_msb = 22;
    localparam int unsigned region_sel_lsb = 20;

    localparam logic [2:0] status_sel = 3'd1;
    localparam logic [2:0] dsp_sel = 3'd2;
    localparam logic [2:0] pad_sel = 3'd3;

    // quad I/O fast read
    localparam logic [7:0] flash_cmd_fast_read = 8'heb;

    typedef enum logic [2:0] {idle, command, address, dummy, data, done} flash_state_t;

    localparam int dummy_cycles_default = 4;

endpackage

//--- common/periph_bus_if.sv
// Decoded request bundle from the address decoder to the peripherals.
// req is a one-cycle pulse; region, write, addr and wdata hold until the next request.

`timescale 1ns/10ps

interface periph_bus_if;
    import periph_pkg::*;

    region_t region;
    logic req;
    logic write;
    cpu_addr_t addr;
    cpu_word_t wdata;

    modport master (
        output region, req, write, addr, wdata
    );

    modport target (
        input region, req, write, addr, wdata
    );

endinterface

//--- logic/address_decoder.sv
// Registers a held CPU request and issues one decoded req pulse for it.
// A new request is only accepted after mem_valid has been seen low.

`timescale 1ns/10ps

module address_decoder (
    input logic vdp_clk,
    input logic vdp_reset,
    input logic mem_valid,
    input periph_pkg::cpu_addr_t mem_addr,
    input periph_pkg::cpu_word_t mem_wdata,
    input periph_pkg::cpu_strb_t mem_wstrb,
    periph_bus_if.master bus
);
    import periph_pkg::*;

    logic issued;
    logic accept;

    function automatic region_t decode_region(input cpu_addr_t a);
        logic [2:0] sel;
        sel = a[region_sel_msb:region_sel_lsb];
        if (a[flash_sel_bit]) begin
            return region_flash;
        end
        case (sel)
            status_sel: return region_status;
            dsp_sel: return region_dsp;
            pad_sel: return region_pad;
            default: return region_none;
        endcase
    endfunction

    // first edge of a request that has not been issued yet
    assign accept = mem_valid && !issued;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            bus.req <= 1'b0;
            issued <= 1'b0;
            bus.region <= region_none;
            bus.write <= 1'b0;
        end else begin
            bus.req <= accept;
            if (accept) begin
                issued <= 1'b1;
                bus.region <= decode_region(mem_addr);
                bus.write <= |mem_wstrb;
            end else if (!mem_valid) begin
                issued <= 1'b0;
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            bus.addr <= mem_addr;
            bus.wdata <= mem_wdata;
        end
    end

endmodule

//--- logic/bus_arbiter.sv
// Returns mem_ready and mem_rdata for each decoded request.
// Register regions, unmapped addresses and flash writes answer one cycle after req,
// flash reads answer one cycle after flash_ready.

`timescale 1ns/10ps

module bus_arbiter (
    input logic vdp_clk,
    input logic vdp_reset,
    periph_bus_if.target bus,
    input periph_pkg::cpu_word_t reg_rdata,
    input periph_pkg::cpu_word_t flash_rdata,
    input logic flash_ready,
    output logic mem_ready,
    output periph_pkg::cpu_word_t mem_rdata
);
    import periph_pkg::*;

    logic flash_busy;
    logic flash_read;
    cpu_word_t rdata_sel;

    assign flash_read = bus.region == region_flash && !bus.write;

    always_comb begin
        case (bus.region)
            region_status, region_dsp, region_pad: rdata_sel = reg_rdata;
            region_flash: rdata_sel = flash_rdata;
            default: rdata_sel = '0;
        endcase
        if (bus.write) begin
            rdata_sel = '0;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            mem_ready <= 1'b0;
            flash_busy <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            if (bus.req) begin
                if (flash_read) begin
                    flash_busy <= 1'b1;
                end else begin
                    mem_ready <= 1'b1;
                end
            end
            if (flash_busy && flash_ready) begin
                flash_busy <= 1'b0;
                mem_ready <= 1'b1;
            end
        end
    end

    // captured in the same edge that raises mem_ready
    always_ff @(posedge vdp_clk) begin
        if (bus.req || flash_ready) begin
            mem_rdata <= rdata_sel;
        end
    end

endmodule

//--- logic/io_regs.sv
// Status LEDs, signed 16x16 multiplier and a mocked three-button gamepad.
// The product lags an operand write by one cycle.
// Gamepad: control bit 0 latches, a rising edge of bit 1 shifts right.

`timescale 1ns/10ps

module io_regs (
    input logic vdp_clk,
    input logic vdp_reset,
    periph_bus_if.target bus,
    input logic [2:0] btn,
    output logic led_r,
    output logic led_b,
    output periph_pkg::cpu_word_t reg_rdata
);
    import periph_pkg::*;

    logic write_en;
    logic [1:0] status;
    logic signed [15:0] dsp_a;
    logic signed [15:0] dsp_b;
    cpu_word_t dsp_product;
    logic [1:0] pad_ctrl;
    logic pad_clk_r;
    logic [15:0] pad_state;

    assign write_en = bus.req && bus.write;

    assign led_r = status[0];
    assign led_b = status[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= 2'b01;
        end else if (write_en && bus.region == region_status) begin
            status <= bus.wdata[1:0];
        end
    end

    // address bit 2 picks operand b
    always_ff @(posedge vdp_clk) begin
        if (write_en && bus.region == region_dsp && !bus.addr[2]) begin
            dsp_a <= bus.wdata[15:0];
        end
        if (write_en && bus.region == region_dsp && bus.addr[2]) begin
            dsp_b <= bus.wdata[15:0];
        end
        dsp_product <= dsp_a * dsp_b;
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl <= 2'b00;
            pad_clk_r <= 1'b0;
            pad_state <= '0;
        end else begin
            if (write_en && bus.region == region_pad) begin
                pad_ctrl <= bus.wdata[1:0];
            end
            pad_clk_r <= pad_ctrl[1];
            if (pad_ctrl[1] && !pad_clk_r) begin
                pad_state <= {1'b0, pad_state[15:1]};
            end else if (pad_ctrl[0]) begin
                // btn[1] at bit 7, btn[2] at bit 6, btn[0] at bit 0
                pad_state <= {8'b0, btn[1], btn[2], 5'b0, btn[0]};
            end
        end
    end

    always_comb begin
        case (bus.region)
            region_status: reg_rdata = {30'b0, status};
            region_dsp: reg_rdata = dsp_product;
            region_pad: reg_rdata = {31'b0, pad_state[0]};
            default: reg_rdata = '0;
        endcase
    end

endmodule

//--- flash/flash_cycle_counter.sv
// 5-bit down-counter timing each flash phase.
// done is high on the last enabled count; load wins over counting.

`timescale 1ns/10ps

module flash_cycle_counter #(
    parameter int dummy_cycles = periph_pkg::dummy_cycles_default
) (
    input logic vdp_clk,
    input logic vdp_reset,
    input logic load,
    input logic enable,
    input logic [4:0] value,
    output logic done
);
    logic [4:0] count;

    // longest phase must fit the 5-bit count
    if (dummy_cycles < 1 || dummy_cycles > 32) begin : g_range_check
        $error("dummy_cycles must be within 1 to 32");
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            count <= 5'd0;
        end else if (load) begin
            count <= value;
        end else if (enable && count != 5'd0) begin
            count <= count - 5'd1;
        end
    end

    assign done = enable && count == 5'd0;

endmodule

//--- flash/flash_shift_reg.sv
// Output shifter holds the command byte and the 24-bit address (upper 4 bits zero),
// top nibble first. Input shifter assembles 8 data nibbles, first nibble on top.

`timescale 1ns/10ps

module flash_shift_reg (
    input logic vdp_clk,
    input logic load_cmd,
    input logic shift_out,
    input logic shift_in,
    input periph_pkg::flash_addr_t addr,
    input logic [3:0] flash_out,
    output logic [3:0] flash_in,
    output periph_pkg::cpu_word_t rdata
);
    import periph_pkg::*;

    cpu_word_t out_shift;

    always_ff @(posedge vdp_clk) begin
        if (load_cmd) begin
            out_shift <= {flash_cmd_fast_read, 4'h0, addr};
        end else if (shift_out) begin
            out_shift <= {out_shift[27:0], 4'h0};
        end
    end

    assign flash_in = out_shift[31:28];

    // msb nibble arrives first
    always_ff @(posedge vdp_clk) begin
        if (shift_in) begin
            rdata <= {rdata[27:0], flash_out};
        end
    end

endmodule

//--- flash/flash_dma_fsm.sv
// Sequences one quad fast read: 2 command nibbles, 6 address nibbles,
// dummy_cycles turnaround cycles and 8 data nibbles, then pulses flash_ready.
// Flash writes are not started here.

`timescale 1ns/10ps

module flash_dma_fsm #(
    parameter int dummy_cycles = periph_pkg::dummy_cycles_default
) (
    input logic vdp_clk,
    input logic vdp_reset,
    periph_bus_if.target bus,
    output logic cnt_load,
    output logic cnt_enable,
    output logic [4:0] cnt_value,
    input logic cnt_done,
    output logic load_cmd,
    output logic shift_out,
    output logic shift_in,
    output logic flash_clk_en,
    output logic flash_csn,
    output logic [3:0] flash_in_en,
    output logic flash_ready
);
    import periph_pkg::*;

    // counter values are phase length minus one
    localparam logic [4:0] cmd_last = 5'd1;
    localparam logic [4:0] addr_last = 5'd5;
    localparam logic [4:0] dummy_last = 5'(dummy_cycles - 1);
    localparam logic [4:0] data_last = 5'd7;

    flash_state_t state;
    flash_state_t next_state;
    logic start;
    logic active;

    assign start = bus.req && bus.region == region_flash && !bus.write;

    always_comb begin
        next_state = state;
        cnt_load = 1'b0;
        cnt_value = 5'd0;
        load_cmd = 1'b0;
        case (state)
            idle: if (start) begin
                next_state = command;
                cnt_load = 1'b1;
                cnt_value = cmd_last;
                load_cmd = 1'b1;
            end
            command: if (cnt_done) begin
                next_state = address;
                cnt_load = 1'b1;
                cnt_value = addr_last;
            end
            address: if (cnt_done) begin
                next_state = dummy;
                cnt_load = 1'b1;
                cnt_value = dummy_last;
            end
            dummy: if (cnt_done) begin
                next_state = data;
                cnt_load = 1'b1;
                cnt_value = data_last;
            end
            data: if (cnt_done) begin
                next_state = done;
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // flash pins follow the state
    assign active = state inside {command, address, dummy, data};
    assign flash_clk_en = active;
    assign flash_csn = !active;
    assign cnt_enable = active;
    assign shift_out = state == command || state == address;
    assign shift_in = state == data;
    assign flash_in_en = shift_out ? 4'hf : 4'h0;
    assign flash_ready = state == done;

endmodule

//--- logic/periph_subsystem.sv
// Peripheral side of the console SoC on vdp_clk only.
// CPU bus: hold mem_valid, address, data and strobes until the one-cycle mem_ready.
// Flash reads stall the bus until the whole quad fetch has completed.

`timescale 1ns/10ps

module periph_subsystem #(
    parameter int dummy_cycles = periph_pkg::dummy_cycles_default
) (
    input logic vdp_clk,
    input logic vdp_reset,

    input logic mem_valid,
    input periph_pkg::cpu_addr_t mem_addr,
    input periph_pkg::cpu_word_t mem_wdata,
    input periph_pkg::cpu_strb_t mem_wstrb,
    output logic mem_ready,
    output periph_pkg::cpu_word_t mem_rdata,

    input logic [2:0] btn,
    output logic led_r,
    output logic led_b,

    output logic flash_clk_en,
    output logic flash_csn,
    output logic [3:0] flash_in,
    output logic [3:0] flash_in_en,
    input logic [3:0] flash_out
);
    import periph_pkg::*;

    cpu_word_t reg_rdata;
    cpu_word_t flash_rdata;
    logic flash_ready;
    logic cnt_load;
    logic cnt_enable;
    logic [4:0] cnt_value;
    logic cnt_done;
    logic load_cmd;
    logic shift_out;
    logic shift_in;

    periph_bus_if bus ();

    address_decoder decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .bus(bus.master)
    );

    bus_arbiter arbiter (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.target),
        .reg_rdata(reg_rdata),
        .flash_rdata(flash_rdata),
        .flash_ready(flash_ready),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

    io_regs regs (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.target),
        .btn(btn),
        .led_r(led_r),
        .led_b(led_b),
        .reg_rdata(reg_rdata)
    );

    flash_dma_fsm #(
        .dummy_cycles(dummy_cycles)
    ) flash_fsm (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.target),
        .cnt_load(cnt_load),
        .cnt_enable(cnt_enable),
        .cnt_value(cnt_value),
        .cnt_done(cnt_done),
        .load_cmd(load_cmd),
        .shift_out(shift_out),
        .shift_in(shift_in),
        .flash_clk_en(flash_clk_en),
        .flash_csn(flash_csn),
        .flash_in_en(flash_in_en),
        .flash_ready(flash_ready)
    );

    flash_cycle_counter #(
        .dummy_cycles(dummy_cycles)
    ) flash_counter (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .load(cnt_load),
        .enable(cnt_enable),
        .value(cnt_value),
        .done(cnt_done)
    );

    // flash byte address is the low 20 bits of the held request
    flash_shift_reg flash_shifter (
        .vdp_clk(vdp_clk),
        .load_cmd(load_cmd),
        .shift_out(shift_out),
        .shift_in(shift_in),
        .addr(bus.addr[19:0]),
        .flash_out(flash_out),
        .flash_in(flash_in),
        .rdata(flash_rdata)
    );

endmodule

//--- bench/periph_subsystem_asserts.sv
// Protocol assertions bound into periph_subsystem.
// Covers the one-cycle mem_ready pulse, an undriven idle flash bus
// and the bus and flash state right after reset.

`timescale 1ns/10ps

module periph_subsystem_asserts (
    input logic vdp_clk,
    input logic vdp_reset,
    input logic mem_ready,
    input logic flash_csn,
    input logic [3:0] flash_in_en
);

    // number of failed assertions
    int fail_count = 0;

    // one ready pulse per request
    ready_one_cycle: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset) mem_ready |=> !mem_ready
    ) else begin
        $error("mem_ready was high for more than one cycle");
        fail_count++;
    end

    idle_flash_undriven: assert property (
        @(posedge vdp_clk) flash_csn |-> flash_in_en == 4'h0
    ) else begin
        $error("flash_in_en driven while flash_csn is high");
        fail_count++;
    end

    reset_state: assert property (
        @(posedge vdp_clk) vdp_reset |=> !mem_ready && flash_csn
    ) else begin
        $error("mem_ready or flash_csn wrong after reset");
        fail_count++;
    end

endmodule

bind periph_subsystem periph_subsystem_asserts periph_asserts_i (
    .vdp_clk(vdp_clk),
    .vdp_reset(vdp_reset),
    .mem_ready(mem_ready),
    .flash_csn(flash_csn),
    .flash_in_en(flash_in_en)
);

//--- bench/tb_periph_subsystem.sv
// Testbench for the peripheral subsystem, driven from bench/periph_patterns.txt.
// Must run from the project root. The flash model answers every fast read
// with {addr[15:0], ~addr[15:0]}. Inputs change on the falling clock edge.

`timescale 1ns/10ps

module tb_periph_subsystem;

    localparam int dummy_cycles = 4;
    localparam int max_patterns = 64;
    localparam int cycles_per_pattern = 40;

    logic vdp_clk = 1'b0;
    logic vdp_reset;
    logic mem_valid;
    logic [23:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0] mem_wstrb;
    logic mem_ready;
    logic [31:0] mem_rdata;
    logic [2:0] btn;
    logic led_r;
    logic led_b;
    logic flash_clk_en;
    logic flash_csn;
    logic [3:0] flash_in;
    logic [3:0] flash_in_en;
    logic [3:0] flash_out;

    // four words per pattern: op, addr, wdata, expected
    logic [31:0] patterns [0:4*max_patterns-1];
    int pattern_count = 0;
    logic patterns_loaded = 1'b0;
    integer seed = 32'hfabf4881;

    // flash model state
    int flash_count = 0;
    int fetch_cycles = 0;
    logic [7:0] flash_cmd;
    logic [23:0] flash_addr_seen;
    logic [31:0] flash_word;

    periph_subsystem #(
        .dummy_cycles(dummy_cycles)
    ) periph_subsystem_i (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata),
        .btn(btn),
        .led_r(led_r),
        .led_b(led_b),
        .flash_clk_en(flash_clk_en),
        .flash_csn(flash_csn),
        .flash_in(flash_in),
        .flash_in_en(flash_in_en),
        .flash_out(flash_out)
    );

    always #50 vdp_clk = ~vdp_clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s: got %h, expected %h",
                     $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // btn[1] at bit 7, btn[2] at bit 6, btn[0] at bit 0
    function automatic logic [15:0] pad_bits(input logic [2:0] b);
        logic [15:0] bits;
        bits = 16'h0;
        bits[0] = b[0];
        bits[6] = b[2];
        bits[7] = b[1];
        return bits;
    endfunction

    // starts on a falling edge and returns on a falling edge, one idle cycle later
    task automatic bus_access(input logic [23:0] addr, input logic [31:0] wdata,
                              input logic write, output logic [31:0] rdata,
                              output int cycles);
        mem_valid = 1'b1;
        mem_addr = addr;
        mem_wdata = wdata;
        mem_wstrb = write ? 4'hf : 4'h0;
        cycles = 0;
        do begin
            @(negedge vdp_clk);
            cycles++;
        end while (!mem_ready);
        rdata = mem_rdata;
        mem_valid = 1'b0;
        mem_wstrb = 4'h0;
        @(negedge vdp_clk);
        check_value(32'(mem_ready), 32'h0, "mem_ready after the ready cycle");
    endtask

    task automatic run_pattern(input logic [31:0] op, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [31:0] expected);
        logic [31:0] rdata;
        logic [31:0] random_value;
        logic [15:0] pad_expect;
        int cycles;
        int pulse;
        case (op)
            32'h0: begin
                bus_access(addr[23:0], wdata, 1'b1, rdata, cycles);
                check_value(32'(cycles), 32'd2, "write latency");
                check_value(rdata, expected, "write response data");
                if (addr[23:20] == 4'h1) begin
                    check_value(32'({led_b, led_r}), 32'(wdata[1:0]), "leds after write");
                end
            end
            32'h1: begin
                bus_access(addr[23:0], 32'h0, 1'b0, rdata, cycles);
                check_value(32'(cycles), 32'd2, "read latency");
                check_value(rdata, expected, "read data");
                if (addr[23:20] == 4'h1) begin
                    check_value(32'({led_b, led_r}), 32'(expected[1:0]), "leds");
                end
            end
            32'h2: begin
                bus_access(addr[23:0], 32'h0, 1'b0, rdata, cycles);
                pad_expect = pad_bits(btn);
                check_value(32'(cycles), 32'd2, "pad read latency");
                check_value(rdata, 32'(pad_expect[expected[3:0]]), "pad bit");
            end
            32'h3: begin
                fetch_cycles = 0;
                bus_access(addr[23:0], 32'h0, 1'b0, rdata, cycles);
                check_value(rdata, expected, "flash read data");
                check_value(32'(flash_addr_seen), 32'({4'h0, addr[19:0]}), "flash address");
                check_value(32'(fetch_cycles), 32'(16 + dummy_cycles), "flash cycles");
            end
            32'h4: begin
                // btn[1] and btn[2] differ so that bits 6 and 7 tell them apart
                do begin
                    random_value = $random(seed);
                end while (random_value[1] == random_value[2]);
                btn = random_value[2:0];
            end
            32'h5: begin
                for (pulse = 0; pulse < int'(wdata); pulse++) begin
                    bus_access(addr[23:0], 32'h2, 1'b1, rdata, cycles);
                    check_value(32'(cycles), 32'd2, "pad clock latency");
                    bus_access(addr[23:0], 32'h0, 1'b1, rdata, cycles);
                end
            end
            default: begin
                $display("unknown operation %h in the pattern file", op);
                $display("Done: errors found");
                $fatal(1, "bad pattern file");
            end
        endcase
    endtask

    // quad flash: 2 command, 6 address, dummy, then 8 data cycles
    always @(negedge vdp_clk) begin : flash_model
        if (flash_csn) begin
            if (flash_count != 0) begin
                fetch_cycles = flash_count;
            end
            flash_count = 0;
        end else if (flash_clk_en) begin
            if (flash_count < 2) begin
                check_value(32'(flash_in_en), 32'hf, "flash_in_en in command phase");
                flash_cmd = {flash_cmd[3:0], flash_in};
            end else if (flash_count < 8) begin
                check_value(32'(flash_in_en), 32'hf, "flash_in_en in address phase");
                flash_addr_seen = {flash_addr_seen[19:0], flash_in};
            end else if (flash_count < 8 + dummy_cycles) begin
                check_value(32'(flash_in_en), 32'h0, "flash_in_en in dummy phase");
                if (flash_count == 8) begin
                    check_value(32'(flash_cmd), 32'heb, "flash command byte");
                    flash_word = {flash_addr_seen[15:0], ~flash_addr_seen[15:0]};
                end
            end else begin
                flash_out = flash_word[31:28];
                flash_word = {flash_word[27:0], 4'h0};
            end
            flash_count++;
        end
    end

    initial begin : watchdog
        wait (patterns_loaded);
        repeat (pattern_count * cycles_per_pattern) @(posedge vdp_clk);
        $display("timeout: the run did not finish within %0d cycles",
                 pattern_count * cycles_per_pattern);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int idx;
        vdp_reset = 1'b1;
        mem_valid = 1'b0;
        mem_addr = 24'h0;
        mem_wdata = 32'h0;
        mem_wstrb = 4'h0;
        btn = 3'b000;
        flash_out = 4'h0;
        for (idx = 0; idx < 4 * max_patterns; idx++) begin
            patterns[idx] = 32'hff;
        end
        $readmemh("bench/periph_patterns.txt", patterns);
        while (pattern_count < max_patterns && patterns[4 * pattern_count] != 32'hff) begin
            pattern_count++;
        end
        if (pattern_count == 0) begin
            $display("no patterns could be read from bench/periph_patterns.txt");
            $display("Done: errors found");
            $fatal(1, "missing stimulus");
        end
        patterns_loaded = 1'b1;
        repeat (5) @(negedge vdp_clk);
        vdp_reset = 1'b0;
        check_value(32'(mem_ready), 32'h0, "mem_ready after reset");
        check_value(32'(flash_csn), 32'h1, "flash_csn after reset");
        check_value(32'(flash_clk_en), 32'h0, "flash_clk_en after reset");
        check_value(32'(flash_in_en), 32'h0, "flash_in_en after reset");
        check_value(32'({led_b, led_r}), 32'h1, "leds after reset");
        for (idx = 0; idx < pattern_count; idx++) begin
            run_pattern(patterns[4 * idx], patterns[4 * idx + 1],
                        patterns[4 * idx + 2], patterns[4 * idx + 3]);
        end
        // bound protocol assertions count their own failures
        if (periph_subsystem_i.periph_asserts_i.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- bench/periph_patterns.txt
// columns (hex): op addr wdata expected
// op 0 write, 1 read, 2 pad read (expected = shift count), 3 flash read,
// op 4 new random buttons, 5 pad clock pulses (wdata = count), ff ends the list
1 100000 00000000 00000001
0 100000 00000002 00000000
1 100000 00000000 00000002
0 200000 00000007 00000000
0 200004 00000006 00000000
1 200000 00000000 0000002a
0 200000 0000fffd 00000000
1 200004 00000000 ffffffee
0 200004 00008000 00000000
1 200000 00000000 00018000
4 000000 00000000 00000000
0 300000 00000001 00000000
0 300000 00000000 00000000
2 300000 00000000 00000000
5 300000 00000001 00000000
2 300000 00000000 00000001
5 300000 00000005 00000000
2 300000 00000000 00000006
5 300000 00000001 00000000
2 300000 00000000 00000007
5 300000 00000001 00000000
2 300000 00000000 00000008
3 801234 00000000 1234edcb
3 8abcde 00000000 bcde4321
3 8f5a0c 00000000 5a0ca5f3
1 000010 00000000 00000000
1 500000 00000000 00000000
1 700004 00000000 00000000
ff 000000 00000000 00000000

//--- vlog.f
common/periph_pkg.sv
common/periph_bus_if.sv
logic/address_decoder.sv
logic/bus_arbiter.sv
logic/io_regs.sv
flash/flash_cycle_counter.sv
flash/flash_shift_reg.sv
flash/flash_dma_fsm.sv
logic/periph_subsystem.sv
bench/periph_subsystem_asserts.sv
bench/tb_periph_subsystem.sv

//--- Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP ?= tb_periph_subsystem
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PATTERNS ?= bench/periph_patterns.txt
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM) $(PATTERNS)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
